//--- common/audio_pkg.sv
// audio output path constants
`default_nettype none

package audio_pkg;

    localparam int sample_w = 8;                    // signed voice sample
    localparam int volume_w = 6;                    // unsigned linear volume
    localparam int prod_w   = sample_w + volume_w;  // one scaled voice
    localparam int mix_w    = prod_w + 1;           // two voices summed
    localparam int acc_w    = 32;
    localparam int frac_w   = 14;                   // filter runs in Q14
    localparam int out_w    = 16;

    // dsp mode frame, 12 MHz / 250 = 48 kHz
    localparam int frame_len = 250;
    localparam int bit_count = 32;

    // coefficient * 2^14 as sums of right shifts
    localparam int fb1_shifts [8] = '{0, 2, 3, 6, 7, 9, 10, 14};  // 1.4014 on y[n-1]
    localparam int fb2_shifts [6] = '{1, 5, 7, 8, 13, 14};        // 0.5432 on -y[n-2]
    localparam int ff0_shifts [4] = '{5, 8, 12, 14};              // 0.0354 on x[n], x[n-2]
    localparam int ff1_shifts [4] = '{4, 7, 11, 14};              // 0.0709 on x[n-1]

    localparam logic [6:0] codec_addr = 7'h1a;      // write byte 0x34

    // register address, then 9 data bits
    localparam int init_count = 8;
    localparam logic [15:0] init_words [init_count] = '{
        {7'h0f, 9'b000000000},  // reset
        {7'h06, 9'b001100111},  // power down adc, mic, line in
        {7'h02, 9'b101111001},  // headphone 0 dB, both channels
        {7'h04, 9'b011010010},  // dac select
        {7'h05, 9'b000000000},  // unmute, no de-emphasis
        {7'h07, 9'b000000011},  // dsp mode
        {7'h08, 9'b000000001},  // usb mode 12 MHz, 48 kHz
        {7'h09, 9'b000000001}   // activate
    };

endpackage

`default_nettype wire

//--- verilog/voice_mixer.sv
// four voice mixer
`timescale 1ns/1ps
`default_nettype none

module voice_mixer (
    input  wire                                  clk_12,
    input  wire                                  reset_n,
    input  wire        [audio_pkg::volume_w-1:0] volume0,
    input  wire        [audio_pkg::volume_w-1:0] volume1,
    input  wire        [audio_pkg::volume_w-1:0] volume2,
    input  wire        [audio_pkg::volume_w-1:0] volume3,
    input  wire signed [audio_pkg::sample_w-1:0] sample0,
    input  wire signed [audio_pkg::sample_w-1:0] sample1,
    input  wire signed [audio_pkg::sample_w-1:0] sample2,
    input  wire signed [audio_pkg::sample_w-1:0] sample3,
    input  wire                                  mix_ready,
    output logic                                 mix_valid,
    output logic signed [audio_pkg::mix_w-1:0]   mix_left,
    output logic signed [audio_pkg::mix_w-1:0]   mix_right
);

    logic [audio_pkg::volume_w-1:0]        vol_a [4];
    logic [audio_pkg::volume_w-1:0]        vol_s [4];
    logic signed [audio_pkg::sample_w-1:0] smp_a [4];
    logic signed [audio_pkg::sample_w-1:0] smp_s [4];
    logic signed [audio_pkg::prod_w-1:0]   prod  [4];
    logic [1:0]                            fill;

    // volume as a sum of shifted copies of the sample
    function automatic logic signed [audio_pkg::prod_w-1:0] scale(
        input logic signed [audio_pkg::sample_w-1:0] smp,
        input logic        [audio_pkg::volume_w-1:0] vol
    );
        logic signed [audio_pkg::prod_w-1:0] acc;
        acc = '0;
        for (int i = 0; i < audio_pkg::volume_w; i++) begin
            if (vol[i])
                acc = acc + (audio_pkg::prod_w'(smp) <<< i);
        end
        return acc;
    endfunction

    // two ranks into the clk_12 domain
    always_ff @(posedge clk_12) begin
        vol_a <= '{volume0, volume1, volume2, volume3};
        smp_a <= '{sample0, sample1, sample2, sample3};
        vol_s <= vol_a;
        smp_s <= smp_a;
    end

    always_ff @(posedge clk_12 or negedge reset_n) begin
        if (!reset_n)
            fill <= 2'b00;
        else
            fill <= {fill[0], 1'b1};  // valid once both ranks hold input
    end

    always_comb begin
        for (int v = 0; v < 4; v++)
            prod[v] = scale(smp_s[v], vol_s[v]);
    end

    assign mix_valid = fill[1];
    assign mix_left  = audio_pkg::mix_w'(prod[1]) + audio_pkg::mix_w'(prod[2]);
    assign mix_right = audio_pkg::mix_w'(prod[0]) + audio_pkg::mix_w'(prod[3]);

endmodule

`default_nettype wire

//--- lowpass/lowpass_biquad.sv
// stereo butterworth low-pass, shift-add
`timescale 1ns/1ps
`default_nettype none

module lowpass_biquad (
    input  wire                                clk_12,
    input  wire                                reset_n,
    input  wire                                mix_valid,
    input  wire signed [audio_pkg::mix_w-1:0]  mix_left,
    input  wire signed [audio_pkg::mix_w-1:0]  mix_right,
    input  wire                                filt_ready,
    output logic                               mix_ready,
    output logic                               filt_valid,
    output logic        [audio_pkg::out_w-1:0] filt_left,
    output logic        [audio_pkg::out_w-1:0] filt_right
);

    // index 0 is left, 1 is right
    logic signed [audio_pkg::acc_w-1:0] x0 [2];
    logic signed [audio_pkg::acc_w-1:0] x1 [2];
    logic signed [audio_pkg::acc_w-1:0] x2 [2];
    logic signed [audio_pkg::acc_w-1:0] y0 [2];
    logic signed [audio_pkg::acc_w-1:0] y1 [2];
    logic signed [audio_pkg::acc_w-1:0] y2 [2];

    function automatic logic signed [audio_pkg::acc_w-1:0] biquad(
        input logic signed [audio_pkg::acc_w-1:0] xn, xn1, xn2, yn1, yn2
    );
        logic signed [audio_pkg::acc_w-1:0] neg_y2;
        logic signed [audio_pkg::acc_w-1:0] acc;
        neg_y2 = -yn2;
        acc    = '0;
        for (int i = 0; i < $size(audio_pkg::fb1_shifts); i++)
            acc += yn1 >>> audio_pkg::fb1_shifts[i];
        for (int i = 0; i < $size(audio_pkg::fb2_shifts); i++)
            acc += neg_y2 >>> audio_pkg::fb2_shifts[i];
        for (int i = 0; i < $size(audio_pkg::ff0_shifts); i++)
            acc += (xn >>> audio_pkg::ff0_shifts[i]) + (xn2 >>> audio_pkg::ff0_shifts[i]);
        for (int i = 0; i < $size(audio_pkg::ff1_shifts); i++)
            acc += xn1 >>> audio_pkg::ff1_shifts[i];
        return acc;
    endfunction

    // channel sum lands at bit 14
    assign x0[0] = audio_pkg::acc_w'(mix_left) <<< audio_pkg::frac_w;
    assign x0[1] = audio_pkg::acc_w'(mix_right) <<< audio_pkg::frac_w;

    always_comb begin
        for (int c = 0; c < 2; c++)
            y0[c] = biquad(x0[c], x1[c], x2[c], y1[c], y2[c]);
    end

    // pass-through handshake
    assign filt_valid = mix_valid;
    assign mix_ready  = filt_ready;

    assign filt_left  = y0[0][audio_pkg::frac_w +: audio_pkg::out_w];  // bits 29:14
    assign filt_right = y0[1][audio_pkg::frac_w +: audio_pkg::out_w];

    always_ff @(posedge clk_12 or negedge reset_n) begin
        if (!reset_n) begin
            for (int c = 0; c < 2; c++) begin
                x1[c] <= '0;
                x2[c] <= '0;
                y1[c] <= '0;
                y2[c] <= '0;
            end
        end else if (filt_valid && filt_ready) begin
            for (int c = 0; c < 2; c++) begin  // history moves one sample
                x1[c] <= x0[c];
                x2[c] <= x1[c];
                y1[c] <= y0[c];
                y2[c] <= y1[c];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/dsp_frame_serializer.sv
// dsp mode frame serializer
`timescale 1ns/1ps
`default_nettype none

module dsp_frame_serializer (
    input  wire                          clk_12,
    input  wire                          reset_n,
    input  wire                          codec_ready,
    input  wire                          filt_valid,
    input  wire [audio_pkg::out_w-1:0]   filt_left,
    input  wire [audio_pkg::out_w-1:0]   filt_right,
    output logic                         filt_ready,
    output logic                         ac_bclk,
    output logic                         ac_lr,
    output logic                         ac_dat
);

    logic [7:0]                         count;
    logic [7:0]                         count_next;
    logic [audio_pkg::bit_count-1:0]    shreg;  // left msb first, then right
    logic                               start;
    logic                               last_bit_span;

    // sample taken only at the top of a frame
    assign filt_ready = codec_ready && (count == 8'd0);
    assign start      = filt_ready && filt_valid;

    // bclk pulses on counts 1, 5, ... 125
    assign last_bit_span = (count <= 8'(4 * audio_pkg::bit_count - 3));

    always_comb begin
        if (count == 8'(audio_pkg::frame_len - 1))
            count_next = 8'd0;
        else if (count != 8'd0 || start)
            count_next = count + 8'd1;
        else
            count_next = count;  // parked at 0 until a sample is taken
    end

    always_ff @(posedge clk_12 or negedge reset_n) begin
        if (!reset_n) begin
            count   <= 8'd0;
            shreg   <= '0;
            ac_bclk <= 1'b0;
            ac_lr   <= 1'b0;
        end else begin
            count   <= count_next;
            ac_bclk <= (count_next[1:0] == 2'b01) &&
                       (count_next <= 8'(4 * audio_pkg::bit_count - 3));
            ac_lr   <= (count_next == 8'd1) || (count_next == 8'd2);  // frame strobe
            if (start)
                shreg <= {filt_left, filt_right};
            else if (count[1:0] == 2'b01 && last_bit_span)
                shreg <= shreg << 1;  // next bit as bclk falls
        end
    end

    assign ac_dat = shreg[audio_pkg::bit_count-1];

endmodule

`default_nettype wire

//--- codec_config/codec_init_seq.sv
// codec register init sequencer
`timescale 1ns/1ps
`default_nettype none

module codec_init_seq (
    input  wire         clk_12,
    input  wire         reset_n,
    input  wire         cmd_ready,
    output logic        cmd_valid,
    output logic [15:0] cmd_word,
    output logic        codec_ready
);

    logic [$clog2(audio_pkg::init_count+1)-1:0] index;

    // index past the table only while valid is low
    assign cmd_word = audio_pkg::init_words[index[$clog2(audio_pkg::init_count)-1:0]];

    always_ff @(posedge clk_12 or negedge reset_n) begin
        if (!reset_n) begin
            index       <= '0;
            cmd_valid   <= 1'b0;
            codec_ready <= 1'b0;
        end else begin
            if (cmd_valid && cmd_ready) begin
                cmd_valid <= 1'b0;
                index     <= index + 1'b1;
            end else if (!cmd_valid && index < audio_pkg::init_count) begin
                cmd_valid <= 1'b1;
            end

            // writer back in idle after the last word
            if (index == audio_pkg::init_count && !cmd_valid && cmd_ready)
                codec_ready <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- codec_config/twowire_writer.sv
// two-wire bus writer, write only
`timescale 1ns/1ps
`default_nettype none

module twowire_writer (
    input  wire        clk_12,
    input  wire        reset_n,
    input  wire        cmd_valid,
    input  wire [15:0] cmd_word,
    output logic       cmd_ready,
    output logic       ac_sclk,
    inout  wire        ac_sdat
);

    typedef enum logic [3:0] {
        st_idle,
        st_bit_low,
        st_bit_high,
        st_ack_low,
        st_ack_high,
        st_ack_wait,
        st_stop_low,
        st_stop_high,
        st_stop_end
    } state_t;

    state_t      state;
    logic        sda_low;   // open drain, only ever pulls low
    logic [7:0]  shreg;
    logic [2:0]  bit_cnt;
    logic [1:0]  byte_cnt;
    logic [15:0] word;

    assign cmd_ready = (state == st_idle);
    assign ac_sdat   = sda_low ? 1'b0 : 1'bz;

    always_ff @(posedge clk_12) begin
        if (cmd_valid && cmd_ready)
            word <= cmd_word;
    end

    always_ff @(posedge clk_12 or negedge reset_n) begin
        if (!reset_n) begin
            state    <= st_idle;
            ac_sclk  <= 1'b1;
            sda_low  <= 1'b0;
            shreg    <= 8'd0;
            bit_cnt  <= 3'd0;
            byte_cnt <= 2'd0;
        end else begin
            case (state)
                st_idle: begin
                    if (cmd_valid) begin
                        sda_low  <= 1'b1;  // start, sda falls with sclk high
                        shreg    <= {audio_pkg::codec_addr, 1'b0};
                        bit_cnt  <= 3'd7;
                        byte_cnt <= 2'd0;
                        state    <= st_bit_low;
                    end
                end
                st_bit_low: begin
                    ac_sclk <= 1'b0;
                    sda_low <= ~shreg[7];
                    state   <= st_bit_high;
                end
                st_bit_high: begin
                    ac_sclk <= 1'b1;
                    if (bit_cnt == 3'd0) begin
                        state <= st_ack_low;
                    end else begin
                        shreg   <= {shreg[6:0], 1'b0};
                        bit_cnt <= bit_cnt - 3'd1;
                        state   <= st_bit_low;
                    end
                end
                st_ack_low: begin
                    ac_sclk <= 1'b0;
                    sda_low <= 1'b0;  // hand the line to the codec
                    state   <= st_ack_high;
                end
                st_ack_high: begin
                    ac_sclk <= 1'b1;
                    state   <= st_ack_wait;
                end
                st_ack_wait: begin
                    // hold sclk high until the codec acknowledges
                    if (ac_sdat == 1'b0) begin
                        byte_cnt <= byte_cnt + 2'd1;
                        bit_cnt  <= 3'd7;
                        shreg    <= (byte_cnt == 2'd0) ? word[15:8] : word[7:0];
                        state    <= (byte_cnt == 2'd2) ? st_stop_low : st_bit_low;
                    end
                end
                st_stop_low: begin
                    ac_sclk <= 1'b0;
                    sda_low <= 1'b1;
                    state   <= st_stop_high;
                end
                st_stop_high: begin
                    ac_sclk <= 1'b1;
                    state   <= st_stop_end;
                end
                st_stop_end: begin
                    sda_low <= 1'b0;  // stop, sda rises with sclk high
                    state   <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/audio_out_top.sv
// stereo audio output to the codec
`timescale 1ns/1ps
`default_nettype none

module audio_out_top (
    input  wire                                  clk_12,
    input  wire                                  reset_n,
    input  wire        [audio_pkg::volume_w-1:0] volume0,
    input  wire        [audio_pkg::volume_w-1:0] volume1,
    input  wire        [audio_pkg::volume_w-1:0] volume2,
    input  wire        [audio_pkg::volume_w-1:0] volume3,
    input  wire signed [audio_pkg::sample_w-1:0] sample0,
    input  wire signed [audio_pkg::sample_w-1:0] sample1,
    input  wire signed [audio_pkg::sample_w-1:0] sample2,
    input  wire signed [audio_pkg::sample_w-1:0] sample3,
    output wire                                  ac_sclk,
    inout  wire                                  ac_sdat,
    output wire                                  ac_xclk,
    output wire                                  ac_bclk,
    output wire                                  ac_lr,
    output wire                                  ac_dat
);

    wire                                  mix_valid;
    wire                                  mix_ready;
    wire signed [audio_pkg::mix_w-1:0]    mix_left;
    wire signed [audio_pkg::mix_w-1:0]    mix_right;
    wire                                  filt_valid;
    wire                                  filt_ready;
    wire        [audio_pkg::out_w-1:0]    filt_left;
    wire        [audio_pkg::out_w-1:0]    filt_right;
    wire                                  cmd_valid;
    wire                                  cmd_ready;
    wire        [15:0]                    cmd_word;
    wire                                  codec_ready;

    assign ac_xclk = clk_12;  // codec master clock

    voice_mixer u_mixer (
        .clk_12    (clk_12),
        .reset_n   (reset_n),
        .volume0   (volume0),
        .volume1   (volume1),
        .volume2   (volume2),
        .volume3   (volume3),
        .sample0   (sample0),
        .sample1   (sample1),
        .sample2   (sample2),
        .sample3   (sample3),
        .mix_ready (mix_ready),
        .mix_valid (mix_valid),
        .mix_left  (mix_left),
        .mix_right (mix_right)
    );

    lowpass_biquad u_filter (
        .clk_12     (clk_12),
        .reset_n    (reset_n),
        .mix_valid  (mix_valid),
        .mix_left   (mix_left),
        .mix_right  (mix_right),
        .filt_ready (filt_ready),
        .mix_ready  (mix_ready),
        .filt_valid (filt_valid),
        .filt_left  (filt_left),
        .filt_right (filt_right)
    );

    dsp_frame_serializer u_serializer (
        .clk_12      (clk_12),
        .reset_n     (reset_n),
        .codec_ready (codec_ready),
        .filt_valid  (filt_valid),
        .filt_left   (filt_left),
        .filt_right  (filt_right),
        .filt_ready  (filt_ready),
        .ac_bclk     (ac_bclk),
        .ac_lr       (ac_lr),
        .ac_dat      (ac_dat)
    );

    codec_init_seq u_init (
        .clk_12      (clk_12),
        .reset_n     (reset_n),
        .cmd_ready   (cmd_ready),
        .cmd_valid   (cmd_valid),
        .cmd_word    (cmd_word),
        .codec_ready (codec_ready)
    );

    twowire_writer u_writer (
        .clk_12    (clk_12),
        .reset_n   (reset_n),
        .cmd_valid (cmd_valid),
        .cmd_word  (cmd_word),
        .cmd_ready (cmd_ready),
        .ac_sclk   (ac_sclk),
        .ac_sdat   (ac_sdat)
    );

endmodule

`default_nettype wire

//--- dv/tb_audio_ref.svh
// audio path reference model
`ifndef TB_AUDIO_REF_SVH
`define TB_AUDIO_REF_SVH

// linear congruential generator, state lives in the testbench
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

// two scaled voices summed into one channel
function automatic logic signed [14:0] mix_ref(
    input logic signed [7:0] smp_a,
    input logic        [5:0] vol_a,
    input logic signed [7:0] smp_b,
    input logic        [5:0] vol_b
);
    int sum;
    sum = int'(smp_a) * int'(vol_a) + int'(smp_b) * int'(vol_b);
    return sum[14:0];
endfunction

// one biquad step in Q14, coefficients as shift lists
function automatic logic signed [31:0] biquad_ref(
    input logic signed [31:0] xn,
    input logic signed [31:0] xn1,
    input logic signed [31:0] xn2,
    input logic signed [31:0] yn1,
    input logic signed [31:0] yn2
);
    int fb1 [8] = '{0, 2, 3, 6, 7, 9, 10, 14};
    int fb2 [6] = '{1, 5, 7, 8, 13, 14};
    int ff0 [4] = '{5, 8, 12, 14};
    int ff1 [4] = '{4, 7, 11, 14};
    logic signed [31:0] neg_y2;
    logic signed [31:0] acc;
    neg_y2 = -yn2;
    acc    = 32'sd0;
    foreach (fb1[i])
        acc = acc + (yn1 >>> fb1[i]);
    foreach (fb2[i])
        acc = acc + (neg_y2 >>> fb2[i]);  // negated y[n-2]
    foreach (ff0[i])
        acc = acc + (xn >>> ff0[i]) + (xn2 >>> ff0[i]);
    foreach (ff1[i])
        acc = acc + (xn1 >>> ff1[i]);
    return acc;
endfunction

`endif

//--- dv/tb_audio_out.sv
// audio output path testbench
`timescale 1ns/1ps
`default_nettype none

module tb_audio_out;

    localparam int frame_cycles = 250;
    localparam int cfg_cycles   = 700;   // eight bus writes with margin
    localparam int n_random     = 40;
    localparam int n_quiet      = 40;
    localparam int n_post       = 6;
    localparam int limit_cycles = 2 * cfg_cycles
                                + (n_random + n_quiet + n_post + 3) * frame_cycles + 1000;

    logic                clk_12;
    logic                reset_n;
    logic        [5:0]   vol [4];
    logic signed [7:0]   smp [4];
    wire                 ac_sclk;
    tri1                 ac_sdat;    // pull-up on the bus data line
    wire                 ac_xclk;
    wire                 ac_bclk;
    wire                 ac_lr;
    wire                 ac_dat;

    logic [31:0]         lcg_state = 32'd74899;
    logic [15:0]         init_ref [8] = '{16'h1e00, 16'h0c67, 16'h0579, 16'h08d2,
                                          16'h0a00, 16'h0e03, 16'h1001, 16'h1201};
    int                  cycle;
    int                  write_count;
    int                  frames_done;
    bit                  change_req;
    bit                  quiet;
    bit                  post_reset;
    string               test_name;
    logic [31:0]         last_frame;
    logic                ack_drive;

    `include "tb_audio_ref.svh"

    assign ac_sdat = ack_drive ? 1'b0 : 1'bz;

    audio_out_top dut0 (
        .clk_12  (clk_12),
        .reset_n (reset_n),
        .volume0 (vol[0]),
        .volume1 (vol[1]),
        .volume2 (vol[2]),
        .volume3 (vol[3]),
        .sample0 (smp[0]),
        .sample1 (smp[1]),
        .sample2 (smp[2]),
        .sample3 (smp[3]),
        .ac_sclk (ac_sclk),
        .ac_sdat (ac_sdat),
        .ac_xclk (ac_xclk),
        .ac_bclk (ac_bclk),
        .ac_lr   (ac_lr),
        .ac_dat  (ac_dat)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp)
            report_failure($sformatf("Error: %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_frame(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
            report_failure($sformatf("Error: %s expected %h actual %h", name, exp, act));
    endtask

    initial begin
        clk_12 = 1'b0;
        forever #5 clk_12 = ~clk_12;
    end

    always @(posedge clk_12) begin
        cycle = cycle + 1;
        if (cycle > limit_cycles)
            report_failure("timeout, the run did not finish in time");
    end

    // codec master clock follows clk_12
    always @(clk_12) begin
        #1;
        if (ac_xclk !== clk_12)
            report_failure("codec master clock does not follow clk_12");
    end

    // new inputs right after each frame strobe
    always @(posedge clk_12) begin
        logic [31:0] r;
        if (change_req) begin
            change_req = 1'b0;
            for (int v = 0; v < 4; v++) begin
                r = lcg_next();
                vol[v] <= quiet ? 6'd0 : r[21:16];
                smp[v] <= r[31:24];
            end
        end
    end

    // codec bus model, acks every byte and decodes the writes
    logic       sclk_prev;
    logic       sdat_prev;
    int         bitn;
    int         nbytes;
    logic [7:0] byte_sr;
    logic [7:0] bytes [3];

    always @(negedge clk_12) begin
        if (!reset_n) begin
            sclk_prev   = 1'b1;
            sdat_prev   = 1'b1;
            ack_drive   = 1'b0;
            bitn        = 0;
            nbytes      = 0;
            write_count = 0;
        end else begin
            if (ac_sclk && sclk_prev && sdat_prev && !ac_sdat) begin
                bitn   = 0;  // start
                nbytes = 0;
            end else if (ac_sclk && sclk_prev && !sdat_prev && ac_sdat) begin
                if (nbytes != 3)
                    report_failure($sformatf("bus write ended after %0d bytes", nbytes));
                if (write_count >= 8)
                    report_failure("more than eight configuration writes on the bus");
                check_word("bus address byte", 16'h0034, {8'h00, bytes[0]});
                check_word($sformatf("config write %0d", write_count),
                           init_ref[write_count], {bytes[1], bytes[2]});
                write_count = write_count + 1;
            end else if (ac_sclk && !sclk_prev) begin
                if (bitn < 8) begin
                    byte_sr = {byte_sr[6:0], ac_sdat};
                    bitn    = bitn + 1;
                end else begin
                    if (nbytes < 3)
                        bytes[nbytes] = byte_sr;
                    nbytes = nbytes + 1;  // ack clock
                    bitn   = 0;
                end
            end else if (!ac_sclk && sclk_prev) begin
                ack_drive = (bitn == 8);  // hold low through the ack clock
            end
            sclk_prev = ac_sclk;
            sdat_prev = ac_sdat;
        end
    end

    // reference history, index 0 left, 1 right
    logic signed [31:0] rx1 [2];
    logic signed [31:0] rx2 [2];
    logic signed [31:0] ry1 [2];
    logic signed [31:0] ry2 [2];

    task automatic advance_model(output logic [31:0] frame);
        logic signed [14:0] m [2];
        logic signed [31:0] x;
        logic signed [31:0] y;
        m[0] = mix_ref(smp[1], vol[1], smp[2], vol[2]);
        m[1] = mix_ref(smp[0], vol[0], smp[3], vol[3]);
        for (int c = 0; c < 2; c++) begin
            x = {{17{m[c][14]}}, m[c]} <<< 14;
            y = biquad_ref(x, rx1[c], rx2[c], ry1[c], ry2[c]);
            rx2[c] = rx1[c];
            rx1[c] = x;
            ry2[c] = ry1[c];
            ry1[c] = y;
            if (c == 0)
                frame[31:16] = y[29:14];
            else
                frame[15:0] = y[29:14];
        end
    endtask

    // frame capture and timing checks
    logic        lr_prev;
    int          lr_high;
    int          bits;
    bit          in_frame;
    int          last_rise;
    logic [31:0] cap;
    logic [31:0] exp_q [$];

    always @(negedge clk_12) begin
        logic [31:0] exp;
        if (!reset_n) begin
            lr_prev   = 1'b0;
            lr_high   = 0;
            bits      = 0;
            in_frame  = 1'b0;
            last_rise = -1;
            exp_q.delete();
            for (int c = 0; c < 2; c++) begin
                rx1[c] = 32'sd0;
                rx2[c] = 32'sd0;
                ry1[c] = 32'sd0;
                ry2[c] = 32'sd0;
            end
        end else begin
            if (write_count < 8 && (ac_lr || ac_bclk))
                report_failure("audio clocks active before the codec was configured");
            if (ac_lr && !lr_prev) begin
                if (in_frame && bits != 32)
                    report_failure($sformatf("frame had %0d bit clocks instead of 32", bits));
                if (last_rise >= 0 && cycle - last_rise != frame_cycles)
                    report_failure($sformatf("frame strobes %0d cycles apart",
                                             cycle - last_rise));
                last_rise = cycle;
                in_frame  = 1'b1;
                bits      = 0;
                lr_high   = 0;
                advance_model(exp);  // inputs held for this frame
                exp_q.push_back(exp);
                change_req = 1'b1;
            end
            if (ac_lr)
                lr_high = lr_high + 1;
            if (!ac_lr && lr_prev && lr_high != 2)
                report_failure($sformatf("frame strobe high for %0d cycles", lr_high));
            if (ac_bclk) begin
                if (bits >= 32)
                    report_failure("more than 32 bit clocks in one frame");
                cap  = {cap[30:0], ac_dat};
                bits = bits + 1;
                if (bits == 32) begin
                    exp = exp_q.pop_front();
                    check_frame(test_name, exp, cap);
                    if (post_reset)
                        check_frame("silence after reset", 32'h0, cap);
                    last_frame  = cap;
                    frames_done = frames_done + 1;
                end
            end
            lr_prev = ac_lr;
        end
    end

    task automatic wait_frames(input int n);
        int target;
        target = frames_done + n;
        while (frames_done < target)
            @(posedge clk_12);
    endtask

    function automatic bit near_zero(input logic [15:0] ch);
        return (ch == 16'h0000) || (ch == 16'hffff);
    endfunction

    initial begin
        logic [31:0] r;
        cycle       = 0;
        frames_done = 0;
        change_req  = 1'b0;
        quiet       = 1'b0;
        post_reset  = 1'b0;
        ack_drive   = 1'b0;
        test_name   = "random audio";
        reset_n     = 1'b0;
        for (int v = 0; v < 4; v++) begin
            r      = lcg_next();
            vol[v] = r[21:16];
            smp[v] = r[31:24];
        end
        repeat (2) @(posedge clk_12);
        reset_n <= 1'b1;

        wait_frames(n_random);
        if (write_count != 8)
            report_failure("configuration did not make exactly eight writes");

        // volumes to zero, output follows the filter decay
        quiet     = 1'b1;
        test_name = "silence decay";
        wait_frames(n_quiet);
        if (!near_zero(last_frame[31:16]) || !near_zero(last_frame[15:0]))
            report_failure("output did not settle after the volumes went to zero");

        // reset in the middle of audio
        @(posedge clk_12);
        reset_n <= 1'b0;
        repeat (2) @(posedge clk_12);
        reset_n    <= 1'b1;
        post_reset = 1'b1;
        test_name  = "audio after reset";
        wait_frames(n_post);

        if (write_count == 8) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            report_failure("configuration after reset did not make eight writes");
        end
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+dv
common/audio_pkg.sv
verilog/voice_mixer.sv
lowpass/lowpass_biquad.sv
verilog/dsp_frame_serializer.sv
codec_config/codec_init_seq.sv
codec_config/twowire_writer.sv
verilog/audio_out_top.sv
dv/tb_audio_out.sv

//--- run_sim.sh
#!/bin/sh
# build and run the audio output testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f sim.f \
    --top-module tb_audio_out \
    -Mdir obj_dir

./obj_dir/Vtb_audio_out 2>&1 | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed"
    exit 1
fi

echo "simulation passed"
exit 0
